/* list.f */
+incdir+hdl
hdl/joypad_pkg.sv
hdl/axil_pkg.sv
hdl/button_sync.sv
hdl/key_matrix.sv
hdl/p1_regs.sv
hdl/joypad_top.sv
verif/joypad_assert.sv
verif/joypad_tb.sv

/* Bender.yml */
package:
  name: joypad

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/joypad_pkg.sv
      - hdl/axil_pkg.sv
      - hdl/button_sync.sv
      - hdl/key_matrix.sv
      - hdl/p1_regs.sv
      - hdl/joypad_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/joypad_assert.sv
      - verif/joypad_tb.sv

/* verif/joypad_tb.sv */
`default_nettype none

`include "joypad_consts.svh"

module joypad_tb
	import joypad_pkg::*, axil_pkg::*;
();

	logic      clk;
	logic      reset;
	buttons_t  pins;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	logic      irq;

	buttons_t    pins_model;
	select_t     sel_model;
	integer      seed;
	string       name_q[$];
	logic [31:0] got_q[$];
	logic [31:0] exp_q[$];

	joypad_top i_dut (
		.clk      (clk),
		.reset    (reset),
		.pins     (pins),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.irq      (irq)
	);

	bind p1_regs joypad_assert i_joypad_assert (
		.clk      (clk),
		.reset    (reset),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.irq      (irq)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] expected_p1(input buttons_t p, input select_t s);
		logic [3:0] nib;
		for (int i = 0; i < 4; i++) begin
			nib[i] = (p.dir[i] | s.sel_dir) & (p.act[i] | s.sel_act); // off group reads 1
		end
		return {24'h0, 2'b11, s.sel_act, s.sel_dir, nib};
	endfunction

	function automatic buttons_t random_pins();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic compare_values(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timed out while waiting for %s", what);
		$display("TB FAILED");
		$fatal(1, "wait timed out");
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	// compare process
	always @(posedge clk) begin
		while (got_q.size() > 0) begin
			compare_values(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
		end
	end

	always @(posedge clk) begin
		if (i_dut.i_p1_regs.i_joypad_assert.fail_count != 0) begin
			$display("a bound assertion failed before %0t", $time);
			$display("TB FAILED");
			$fatal(1, "assertion failure");
		end
	end

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output resp_e resp);
		int n;
		axil_req.awaddr  = addr;
		axil_req.wdata   = data;
		axil_req.wstrb   = strb;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		n = 0;
		while (!axil_rsp.awready) begin
			@(posedge clk);
			#1;
			n++;
			if (n > 20) report_timeout("awready");
		end
		@(posedge clk); // handshake edge
		#1;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		n = 0;
		while (!axil_rsp.bvalid) begin
			@(posedge clk);
			#1;
			n++;
			if (n > 20) report_timeout("bvalid");
		end
		resp = axil_rsp.bresp;
		axil_req.bready = 1'b1;
		@(posedge clk);
		#1;
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
		output resp_e resp);
		int          n;
		int          hold;
		logic [31:0] first;
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		n = 0;
		while (!axil_rsp.arready) begin
			@(posedge clk);
			#1;
			n++;
			if (n > 20) report_timeout("arready");
		end
		@(posedge clk);
		#1;
		axil_req.arvalid = 1'b0;
		n = 0;
		while (!axil_rsp.rvalid) begin
			@(posedge clk);
			#1;
			n++;
			if (n > 20) report_timeout("rvalid");
		end
		first = axil_rsp.rdata;
		hold = $unsigned($random(seed)) % 4; // back-pressure on rready
		repeat (hold) begin
			@(posedge clk);
			#1;
			compare_values("rvalid", axil_rsp.rvalid, 1'b1);
			compare_values("rdata", axil_rsp.rdata, first);
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		axil_req.rready = 1'b1;
		@(posedge clk);
		#1;
		axil_req.rready = 1'b0;
	endtask

	task automatic check_read(input logic [7:0] addr, input logic [31:0] exp,
		input resp_e exp_resp, input string name);
		logic [31:0] data;
		resp_e       resp;
		axil_read(addr, data, resp);
		expect_value(name, data, exp);
		expect_value({name, " rresp"}, resp, exp_resp);
	endtask

	task automatic write_sel(input select_t s);
		resp_e resp;
		axil_write(`JOY_P1_ADDR, {26'h0, s, 4'h0}, 4'h1, resp);
		sel_model = s;
		expect_value("P1 bresp", resp, RESP_OKAY);
	endtask

	task automatic clear_irq();
		resp_e resp;
		axil_write(`JOY_IRQ_ADDR, 32'h1, 4'h1, resp);
		expect_value("IRQ bresp", resp, RESP_OKAY);
	endtask

	task automatic set_pins(input buttons_t p);
		pins       = p;
		pins_model = p;
	endtask

	// sync plus debounce plus matrix register plus margin
	task automatic settle();
		repeat (`JOY_DEBOUNCE + 6) @(posedge clk);
		#1;
	endtask

	task automatic wait_irq_rise();
		int n;
		n = 0;
		while (!irq) begin
			@(posedge clk);
			#1;
			n++;
			if (n > `JOY_DEBOUNCE + 12) report_timeout("irq to rise");
		end
	endtask

	initial begin
		buttons_t p;
		resp_e    resp;
		int       n;
		seed        = 32'hbf31;
		reset       = 1'b1;
		pins        = '1;
		pins_model  = '1;
		sel_model   = select_t'(2'b11);
		axil_req    = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		compare_values("irq", irq, 1'b0);
		check_read(`JOY_P1_ADDR, expected_p1(pins_model, sel_model), RESP_OKAY, "P1");
		check_read(`JOY_IRQ_ADDR, 32'h0, RESP_OKAY, "IRQ");

		for (int s = 0; s < 4; s++) begin
			for (int k = 0; k < 3; k++) begin
				set_pins(random_pins());
				write_sel(select_t'(s[1:0]));
				settle();
				check_read(`JOY_P1_ADDR, expected_p1(pins_model, sel_model), RESP_OKAY, "P1");
			end
		end

		// right key bounces with each level shorter than the debounce window
		set_pins('1);
		write_sel(select_t'(2'b10));
		settle();
		clear_irq();
		for (int t = 0; t < 8; t++) begin
			pins.dir[0] = ~pins.dir[0]; // model keeps the released level
			repeat (`JOY_DEBOUNCE / 4) @(posedge clk);
			#1;
		end
		check_read(`JOY_P1_ADDR, expected_p1(pins_model, sel_model), RESP_OKAY, "P1");
		compare_values("irq", irq, 1'b0);
		p = '1;
		p.dir[0] = 1'b0;
		set_pins(p);
		settle();
		check_read(`JOY_P1_ADDR, expected_p1(pins_model, sel_model), RESP_OKAY, "P1");

		set_pins('1);
		settle();
		clear_irq();
		check_read(`JOY_IRQ_ADDR, 32'h0, RESP_OKAY, "IRQ");
		p = '1;
		p.dir[2] = 1'b0; // up
		set_pins(p);
		wait_irq_rise();
		check_read(`JOY_IRQ_ADDR, 32'h1, RESP_OKAY, "IRQ");
		clear_irq();
		compare_values("irq", irq, 1'b0);
		check_read(`JOY_IRQ_ADDR, 32'h0, RESP_OKAY, "IRQ");
		p.act[0] = 1'b0; // action group is deselected
		set_pins(p);
		repeat (`JOY_DEBOUNCE + 8) begin
			@(posedge clk);
			#1;
			compare_values("irq", irq, 1'b0);
		end
		check_read(`JOY_IRQ_ADDR, 32'h0, RESP_OKAY, "IRQ");

		axil_write(8'h08, 32'h1, 4'hf, resp);
		expect_value("unmapped bresp", resp, RESP_SLVERR);
		check_read(8'h08, 32'h0, RESP_SLVERR, "unmapped");

		for (int k = 0; k < 6; k++) begin
			set_pins(random_pins());
			write_sel(select_t'(random_pins() >> 4));
			settle();
			check_read(`JOY_P1_ADDR, expected_p1(pins_model, sel_model), RESP_OKAY, "P1");
			check_read(`JOY_P1_ADDR, expected_p1(pins_model, sel_model), RESP_OKAY, "P1");
		end

		n = 0;
		while (got_q.size() > 0) begin
			@(posedge clk);
			#1;
			n++;
			if (n > 4) report_timeout("the compare queue to drain");
		end
		if (i_dut.i_p1_regs.i_joypad_assert.fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/joypad_assert.sv */
`default_nettype none

`include "joypad_consts.svh"

module joypad_assert
	import axil_pkg::*;
(
	input logic      clk,
	input logic      reset,
	input axil_req_t axil_req,
	input axil_rsp_t axil_rsp,
	input logic      irq
);

	logic irq_clear_wr;
	int   fail_count;

	initial fail_count = 0;

	assign irq_clear_wr = axil_rsp.awready & axil_req.awvalid & axil_req.wvalid &
		(axil_req.awaddr == `JOY_IRQ_ADDR) & axil_req.wstrb[0] & axil_req.wdata[0];

	bvalid_held: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
		else begin
			fail_count++;
			$error("bvalid dropped before bready");
		end

	rvalid_held: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
		else begin
			fail_count++;
			$error("rvalid or rdata changed before rready");
		end

	irq_fall_on_clear: assert property (@(posedge clk) disable iff (reset)
		$fell(irq) |-> $past(irq_clear_wr))
		else begin
			fail_count++;
			$error("irq fell without a write to the irq register");
		end

	ready_pair: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.awready == axil_rsp.wready)
		else begin
			fail_count++;
			$error("awready and wready differ");
		end

	ready_pulse: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.awready |=> !axil_rsp.awready)
		else begin
			fail_count++;
			$error("awready held longer than one cycle");
		end

endmodule

`default_nettype wire

/* hdl/joypad_top.sv */
`default_nettype none

module joypad_top
	import joypad_pkg::*, axil_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  buttons_t  pins,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output logic      irq
);

	buttons_t   clean;
	select_t    sel;
	logic [3:0] nibble;
	logic       fall;

	button_sync i_button_sync (
		.clk   (clk),
		.reset (reset),
		.pins  (pins),
		.clean (clean)
	);

	key_matrix i_key_matrix (
		.clk    (clk),
		.reset  (reset),
		.clean  (clean),
		.sel    (sel), // fed back from the register stage
		.nibble (nibble),
		.fall   (fall)
	);

	p1_regs i_p1_regs (
		.clk      (clk),
		.reset    (reset),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.nibble   (nibble),
		.fall     (fall),
		.sel      (sel),
		.irq      (irq)
	);

endmodule

`default_nettype wire

/* hdl/p1_regs.sv */
`default_nettype none

`include "joypad_consts.svh"

module p1_regs
	import joypad_pkg::*, axil_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  axil_req_t  axil_req,
	output axil_rsp_t  axil_rsp,
	input  logic [3:0] nibble,
	input  logic       fall,
	output select_t    sel,
	output logic       irq
);

	logic                   awready_q;
	logic                   bvalid_q;
	logic                   arready_q;
	logic                   rvalid_q;
	resp_e                  bresp_q;
	resp_e                  rresp_q;
	resp_e                  wr_resp;
	resp_e                  rd_resp;
	logic [`JOY_DATA_W-1:0] rdata_q;
	logic [`JOY_DATA_W-1:0] rd_data;
	logic                   wr_fire;
	logic                   rd_fire;
	logic                   p1_wr;
	logic                   irq_clr;
	logic                   flag;
	reg_addr_e              wr_addr;
	reg_addr_e              rd_addr;

	assign wr_fire = awready_q & axil_req.awvalid & axil_req.wvalid;
	assign rd_fire = arready_q & axil_req.arvalid;
	assign wr_addr = reg_addr_e'(axil_req.awaddr);
	assign rd_addr = reg_addr_e'(axil_req.araddr);

	always_comb begin
		p1_wr   = 1'b0;
		irq_clr = 1'b0;
		wr_resp = RESP_OKAY;
		case (wr_addr)
			REG_P1:  p1_wr   = wr_fire & axil_req.wstrb[0];
			REG_IRQ: irq_clr = wr_fire & axil_req.wstrb[0] & axil_req.wdata[0]; // write 1 to clear
			default: wr_resp = RESP_SLVERR;
		endcase
	end

	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (rd_addr)
			REG_P1:  rd_data = {{(`JOY_DATA_W-8){1'b0}}, 2'b11, sel, nibble};
			REG_IRQ: rd_data = {{(`JOY_DATA_W-1){1'b0}}, flag};
			default: rd_resp = RESP_SLVERR; // data stays zero
		endcase
	end

	// write channel, aw and w accepted together
	always_ff @(posedge clk) begin
		if (reset) begin
			awready_q <= 1'b0;
			bvalid_q  <= 1'b0;
			bresp_q   <= RESP_OKAY;
		end else begin
			awready_q <= axil_req.awvalid & axil_req.wvalid & ~awready_q & ~bvalid_q;
			if (wr_fire) begin
				bvalid_q <= 1'b1;
				bresp_q  <= wr_resp;
			end else if (axil_req.bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	// read channel, one outstanding read
	always_ff @(posedge clk) begin
		if (reset) begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
			rresp_q   <= RESP_OKAY;
		end else begin
			arready_q <= axil_req.arvalid & ~arready_q & ~rvalid_q;
			if (rd_fire) begin
				rvalid_q <= 1'b1;
				rresp_q  <= rd_resp;
			end else if (axil_req.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata_q <= rd_data; // held while rvalid waits
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sel  <= select_t'(2'b11); // both groups off
			flag <= 1'b0;
		end else begin
			if (p1_wr) begin
				sel <= select_t'(axil_req.wdata[5:4]);
			end
			flag <= fall | (flag & ~irq_clr); // set beats clear
		end
	end

	always_comb begin
		axil_rsp.awready = awready_q;
		axil_rsp.wready  = awready_q;
		axil_rsp.bresp   = bresp_q;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.arready = arready_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
		axil_rsp.rvalid  = rvalid_q;
	end

	assign irq = flag;

endmodule

`default_nettype wire

/* hdl/key_matrix.sv */
`default_nettype none

module key_matrix
	import joypad_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  buttons_t   clean,
	input  select_t    sel,
	output logic [3:0] nibble,
	output logic       fall
);

	logic [3:0] dir_m;
	logic [3:0] act_m;
	logic [3:0] prev;

	// a deselected group reads as released
	assign dir_m = sel.sel_dir ? 4'hf : clean.dir;
	assign act_m = sel.sel_act ? 4'hf : clean.act;

	always_ff @(posedge clk) begin
		if (reset) begin
			nibble <= 4'hf;
			prev   <= 4'hf;
			fall   <= 1'b0;
		end else begin
			nibble <= dir_m & act_m; // wired-and of both groups
			prev   <= nibble;
			fall   <= |(prev & ~nibble); // any line went 1 to 0
		end
	end

endmodule

`default_nettype wire

/* hdl/button_sync.sv */
`default_nettype none

`include "joypad_consts.svh"

module button_sync
	import joypad_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  buttons_t pins,
	output buttons_t clean
);

	localparam int CNT_W = $clog2(`JOY_DEBOUNCE + 1);

	logic [7:0]       meta;
	logic [7:0]       stable;
	logic [7:0]       clean_q;
	logic [CNT_W-1:0] cnt [8];

	// two flops per pin
	always_ff @(posedge clk) begin
		if (reset) begin
			meta   <= '1;
			stable <= '1;
		end else begin
			meta   <= pins; // may go metastable
			stable <= meta;
		end
	end

	// each pin counts how long it has disagreed with clean
	always_ff @(posedge clk) begin
		if (reset) begin
			clean_q <= '1; // all keys released
			for (int i = 0; i < 8; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 8; i++) begin
				if (stable[i] == clean_q[i]) begin
					cnt[i] <= '0; // bounced back, start over
				end else if (cnt[i] == CNT_W'(`JOY_DEBOUNCE - 1)) begin
					cnt[i]     <= '0;
					clean_q[i] <= stable[i]; // held long enough
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign clean = clean_q;

endmodule

`default_nettype wire

/* hdl/axil_pkg.sv */
`default_nettype none

`include "joypad_consts.svh"

package axil_pkg;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// master to slave
	typedef struct packed {
		logic [`JOY_ADDR_W-1:0] awaddr;
		logic                   awvalid;
		logic [`JOY_DATA_W-1:0] wdata;
		logic [`JOY_STRB_W-1:0] wstrb;
		logic                   wvalid;
		logic                   bready;
		logic [`JOY_ADDR_W-1:0] araddr;
		logic                   arvalid;
		logic                   rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic                   awready;
		logic                   wready;
		resp_e                  bresp;
		logic                   bvalid;
		logic                   arready;
		logic [`JOY_DATA_W-1:0] rdata;
		resp_e                  rresp;
		logic                   rvalid;
	} axil_rsp_t;

endpackage

`default_nettype wire

/* hdl/joypad_pkg.sv */
`default_nettype none

`include "joypad_consts.svh"

package joypad_pkg;

	// raw or debounced keys, all active low
	typedef struct packed {
		logic [3:0] act; // start, select, b, a
		logic [3:0] dir; // down, up, left, right
	} buttons_t;

	// P1 bits 5:4, a 0 selects the group
	typedef struct packed {
		logic sel_act; // P15
		logic sel_dir; // P14
	} select_t;

	typedef enum logic [`JOY_ADDR_W-1:0] {
		REG_P1  = `JOY_P1_ADDR,
		REG_IRQ = `JOY_IRQ_ADDR
	} reg_addr_e;

endpackage

`default_nettype wire

/* hdl/joypad_consts.svh */
`ifndef JOYPAD_CONSTS_SVH
`define JOYPAD_CONSTS_SVH

// AXI4-Lite geometry
`define JOY_ADDR_W 8
`define JOY_DATA_W 32
`define JOY_STRB_W (`JOY_DATA_W / 8) // one strobe per byte

// register map, byte offsets
`define JOY_P1_ADDR  8'h00 // ff00 on the console
`define JOY_IRQ_ADDR 8'h04 // sticky joypad interrupt

// debounce window in clk cycles
`define JOY_DEBOUNCE 16

`endif
